/* Makefile */
# Verilator build and run of the trap path testbench

SRC := $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtrap_tb: sources.f $(SRC)
	verilator --binary --timing --top-module trap_tb -f sources.f -o Vtrap_tb

# Pass only if the log holds the pass line
run: obj_dir/Vtrap_tb
	./obj_dir/Vtrap_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/trap_tb.sv */
// ====================
// Trap path testbench
// Directed tests for CSR access, ID traps, priority,
// flush masking, misaligned accesses and mret
// ====================

`timescale 1ns/100ps

`include "rv_macros.svh"

module trap_tb;

  // About twice the cycle count of all tests
  localparam int test_cycles = 300;

  logic               clk;
  logic               rst_n;
  logic [`XLEN-1:0]   if_pc;
  logic               if_valid;
  logic               id_illegal_inst;
  logic               id_ecall;
  logic               id_ebreak;
  logic               id_mret;
  logic [`XLEN-1:0]   id_pc;
  rv_trap_pkg::inst_u id_instruction;
  logic               id_valid;
  logic [`XLEN-1:0]   mem_addr;
  logic               mem_read;
  logic               mem_write;
  logic [2:0]         mem_funct3;
  logic [`XLEN-1:0]   mem_pc;
  logic               mem_valid;
  logic               csr_valid;
  rv_trap_pkg::inst_u csr_inst;
  logic [`XLEN-1:0]   csr_wdata;
  logic [`XLEN-1:0]   csr_rdata;
  logic               redirect_valid;
  logic [`XLEN-1:0]   redirect_pc;
  logic               flush;

  int          errors;
  int          checks;
  logic [15:0] lfsr_state;
  // mtvec as written during the CSR tests
  logic [31:0] mtvec_val;

  trap_top UUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .if_pc           (if_pc),
    .if_valid        (if_valid),
    .id_illegal_inst (id_illegal_inst),
    .id_ecall        (id_ecall),
    .id_ebreak       (id_ebreak),
    .id_mret         (id_mret),
    .id_pc           (id_pc),
    .id_instruction  (id_instruction),
    .id_valid        (id_valid),
    .mem_addr        (mem_addr),
    .mem_read        (mem_read),
    .mem_write       (mem_write),
    .mem_funct3      (mem_funct3),
    .mem_pc          (mem_pc),
    .mem_valid       (mem_valid),
    .csr_valid       (csr_valid),
    .csr_inst        (csr_inst),
    .csr_wdata       (csr_wdata),
    .csr_rdata       (csr_rdata),
    .redirect_valid  (redirect_valid),
    .redirect_pc     (redirect_pc),
    .flush           (flush)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog
  initial begin
    #(test_cycles * 10 + 2000);
    $display("Watchdog timeout at %0t, the tests did not complete in time", $time);
    $display("Finished with errors");
    $finish;
  end

  // ====================
  // Random values
  // ====================

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    int          i;
    w = '0;
    for (i = 0; i < 32; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[30:0], lfsr_state[15]};
    end
    return w;
  endfunction

  // ====================
  // CSR helpers
  // ====================

  // SYSTEM opcode, rd = x5
  function automatic logic [31:0] csr_word(input logic [2:0] funct3,
                                           input logic [11:0] addr,
                                           input logic [4:0] rs1);
    return {addr, rs1, funct3, 5'd5, 7'b1110011};
  endfunction

  // One CSR instruction, read sampled mid-cycle
  task automatic csr_op(input logic [2:0] funct3, input logic [11:0] addr,
                        input logic [4:0] rs1, input logic [31:0] wdata,
                        output logic [31:0] rdata);
    @(posedge clk);
    csr_valid    <= 1'b1;
    csr_inst.raw <= csr_word(funct3, addr, rs1);
    csr_wdata    <= wdata;
    @(negedge clk);
    rdata = csr_rdata;
    @(posedge clk);
    csr_valid <= 1'b0;
  endtask

  // Write, and check the value returned before the write
  task automatic csr_write(input logic [2:0] funct3, input logic [11:0] addr,
                           input logic [4:0] rs1, input logic [31:0] wdata,
                           input logic [31:0] old, input string what);
    logic [31:0] rdata;
    csr_op(funct3, addr, rs1, wdata, rdata);
    checks++;
    if (rdata !== old) begin
      $display("Error at %0t: %s returned %h, expected old value %h", $time, what, rdata, old);
      errors++;
    end
  endtask

  // Pure read through csrrs with rs1 = x0
  task automatic expect_csr(input logic [11:0] addr, input logic [31:0] expected,
                            input string what);
    logic [31:0] rdata;
    csr_op(3'b010, addr, 5'd0, 32'h0, rdata);
    checks++;
    if (rdata !== expected) begin
      $display("Error at %0t: %s read %h, expected %h", $time, what, rdata, expected);
      errors++;
    end
  endtask

  // ====================
  // Stage and redirect helpers
  // ====================

  task automatic issue_id(input logic ebreak, input logic ecall, input logic illegal,
                          input logic [31:0] pc, input logic [31:0] inst);
    @(posedge clk);
    id_valid           <= 1'b1;
    id_ebreak          <= ebreak;
    id_ecall           <= ecall;
    id_illegal_inst    <= illegal;
    id_pc              <= pc;
    id_instruction.raw <= inst;
    @(posedge clk);
    id_valid        <= 1'b0;
    id_ebreak       <= 1'b0;
    id_ecall        <= 1'b0;
    id_illegal_inst <= 1'b0;
  endtask

  task automatic issue_mem(input logic rd, input logic wr, input logic [2:0] funct3,
                           input logic [31:0] addr, input logic [31:0] pc);
    @(posedge clk);
    mem_valid  <= 1'b1;
    mem_read   <= rd;
    mem_write  <= wr;
    mem_funct3 <= funct3;
    mem_addr   <= addr;
    mem_pc     <= pc;
    @(posedge clk);
    mem_valid <= 1'b0;
    mem_read  <= 1'b0;
    mem_write <= 1'b0;
  endtask

  // Called in the cycle after the event
  task automatic expect_redirect(input logic [31:0] target, input string what);
    @(negedge clk);
    checks++;
    if (!redirect_valid || !flush) begin
      $display("No redirect and flush in the cycle after the %s", what);
      errors++;
    end else if (redirect_pc !== target) begin
      $display("Error at %0t: %s redirect_pc %h, expected %h", $time, what, redirect_pc, target);
      errors++;
    end
  endtask

  task automatic expect_quiet(input string what);
    @(negedge clk);
    checks++;
    if (redirect_valid || flush) begin
      $display("Error at %0t: unexpected redirect or flush, %s", $time, what);
      errors++;
    end
  endtask

  // ====================
  // Directed tests
  // ====================

  task automatic check_reset_state();
    expect_quiet("right after reset");
    expect_csr(rv_trap_pkg::csr_mstatus, 32'h0, "mstatus after reset");
    expect_csr(rv_trap_pkg::csr_mtvec, 32'h0, "mtvec after reset");
    expect_csr(rv_trap_pkg::csr_mepc, 32'h0, "mepc after reset");
    expect_csr(rv_trap_pkg::csr_mcause, 32'h0, "mcause after reset");
    expect_csr(rv_trap_pkg::csr_mtval, 32'h0, "mtval after reset");
    expect_csr(rv_trap_pkg::csr_mmisalign, 32'h0, "mmisalign after reset");
  endtask

  task automatic run_csr_access();
    logic [31:0] val;
    val = rand_word() | 32'h3;
    mtvec_val = val & ~32'h3;
    csr_write(3'b001, rv_trap_pkg::csr_mtvec, 5'd1, val, 32'h0, "mtvec csrrw");
    expect_csr(rv_trap_pkg::csr_mtvec, mtvec_val, "mtvec readback");
    // Set then clear the misalignment enable
    csr_write(3'b010, rv_trap_pkg::csr_mmisalign, 5'd2, 32'h1, 32'h0, "mmisalign csrrs");
    expect_csr(rv_trap_pkg::csr_mmisalign, 32'h1, "mmisalign after set");
    csr_write(3'b011, rv_trap_pkg::csr_mmisalign, 5'd2, 32'h1, 32'h1, "mmisalign csrrc");
    expect_csr(rv_trap_pkg::csr_mmisalign, 32'h0, "mmisalign after clear");
    // MIE and MPIE
    csr_write(3'b010, rv_trap_pkg::csr_mstatus, 5'd3, 32'h88, 32'h0, "mstatus csrrs");
    csr_write(3'b011, rv_trap_pkg::csr_mstatus, 5'd3, 32'h80, 32'h88, "mstatus csrrc");
    expect_csr(rv_trap_pkg::csr_mstatus, 32'h08, "mstatus after clear of MPIE");
    // rs1 = x0 means no write
    csr_write(3'b010, rv_trap_pkg::csr_mstatus, 5'd0, 32'hffff_ffff, 32'h08, "mstatus x0 set");
    csr_write(3'b011, rv_trap_pkg::csr_mtvec, 5'd0, 32'hffff_ffff, mtvec_val, "mtvec x0 clear");
    expect_csr(rv_trap_pkg::csr_mstatus, 32'h08, "mstatus after x0 set");
    expect_csr(rv_trap_pkg::csr_mtvec, mtvec_val, "mtvec after x0 clear");
  endtask

  // kind 0 ebreak, 1 ecall, 2 illegal instruction
  task automatic trap_from_id(input int kind);
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] cause;
    logic [31:0] tval;
    logic [31:0] rdata;
    string       name;
    pc   = rand_word() & ~32'h3;
    inst = rand_word();
    if (kind == 0) begin
      name  = "ebreak";
      cause = 32'd3;
      tval  = pc;
    end else if (kind == 1) begin
      name  = "ecall";
      cause = 32'd11;
      tval  = 32'h0;
    end else begin
      name  = "illegal instruction";
      cause = 32'd2;
      tval  = inst;
    end
    // MIE on, MPIE off
    csr_op(3'b001, rv_trap_pkg::csr_mstatus, 5'd4, 32'h08, rdata);
    issue_id(kind == 0, kind == 1, kind == 2, pc, inst);
    expect_redirect(mtvec_val, name);
    @(posedge clk);
    expect_quiet({name, " redirect is one cycle"});
    expect_csr(rv_trap_pkg::csr_mcause, cause, {name, " mcause"});
    expect_csr(rv_trap_pkg::csr_mepc, pc, {name, " mepc"});
    expect_csr(rv_trap_pkg::csr_mtval, tval, {name, " mtval"});
    expect_csr(rv_trap_pkg::csr_mstatus, 32'h80, {name, " mstatus"});
  endtask

  // Fetch misalignment beats an illegal instruction
  task automatic priority_and_fetch();
    logic [31:0] fpc;
    logic [31:0] ipc;
    fpc = rand_word() | 32'h1;
    ipc = rand_word() & ~32'h3;
    @(posedge clk);
    if_valid           <= 1'b1;
    if_pc              <= fpc;
    id_valid           <= 1'b1;
    id_illegal_inst    <= 1'b1;
    id_pc              <= ipc;
    id_instruction.raw <= rand_word();
    @(posedge clk);
    if_valid        <= 1'b0;
    id_valid        <= 1'b0;
    id_illegal_inst <= 1'b0;
    expect_redirect(mtvec_val, "fetch misalignment");
    @(posedge clk);
    expect_quiet("after fetch misalignment");
    expect_csr(rv_trap_pkg::csr_mcause, 32'd0, "priority mcause");
    expect_csr(rv_trap_pkg::csr_mepc, fpc & ~32'h3, "priority mepc");
    expect_csr(rv_trap_pkg::csr_mtval, fpc, "priority mtval");
  endtask

  // Exception in the redirect cycle is flushed
  task automatic flushed_exception();
    logic [31:0] apc;
    logic [31:0] bpc;
    apc = rand_word() & ~32'h3;
    bpc = rand_word() & ~32'h3;
    @(posedge clk);
    id_valid <= 1'b1;
    id_ecall <= 1'b1;
    id_pc    <= apc;
    @(posedge clk);
    id_ecall           <= 1'b0;
    id_illegal_inst    <= 1'b1;
    id_pc              <= bpc;
    id_instruction.raw <= rand_word();
    expect_redirect(mtvec_val, "ecall ahead of a flushed instruction");
    @(posedge clk);
    id_valid        <= 1'b0;
    id_illegal_inst <= 1'b0;
    expect_quiet("second redirect from a flushed instruction");
    expect_csr(rv_trap_pkg::csr_mcause, 32'd11, "masking mcause");
    expect_csr(rv_trap_pkg::csr_mepc, apc, "masking mepc");
    expect_csr(rv_trap_pkg::csr_mtval, 32'h0, "masking mtval");
  endtask

  task automatic misaligned_access();
    logic [31:0] addr;
    logic [31:0] pc;
    logic [31:0] rdata;
    // Enable bit clear, nothing traps
    issue_mem(1'b1, 1'b0, rv_trap_pkg::width_word, rand_word() | 32'h1, rand_word() & ~32'h3);
    expect_quiet("misaligned load while disabled");
    issue_mem(1'b0, 1'b1, rv_trap_pkg::width_half, rand_word() | 32'h1, rand_word() & ~32'h3);
    expect_quiet("misaligned store while disabled");
    csr_op(3'b010, rv_trap_pkg::csr_mmisalign, 5'd6, 32'h1, rdata);
    // Word load at offset 2
    addr = (rand_word() & ~32'h3) | 32'h2;
    pc   = rand_word() & ~32'h3;
    issue_mem(1'b1, 1'b0, rv_trap_pkg::width_word, addr, pc);
    expect_redirect(mtvec_val, "misaligned load");
    @(posedge clk);
    expect_quiet("after misaligned load");
    expect_csr(rv_trap_pkg::csr_mcause, 32'd4, "load mcause");
    expect_csr(rv_trap_pkg::csr_mtval, addr, "load mtval");
    expect_csr(rv_trap_pkg::csr_mepc, pc, "load mepc");
    // Half store at an odd address
    addr = rand_word() | 32'h1;
    pc   = rand_word() & ~32'h3;
    issue_mem(1'b0, 1'b1, rv_trap_pkg::width_half, addr, pc);
    expect_redirect(mtvec_val, "misaligned store");
    @(posedge clk);
    expect_quiet("after misaligned store");
    expect_csr(rv_trap_pkg::csr_mcause, 32'd6, "store mcause");
    expect_csr(rv_trap_pkg::csr_mtval, addr, "store mtval");
    expect_csr(rv_trap_pkg::csr_mepc, pc, "store mepc");
    // Aligned and byte accesses never trap
    issue_mem(1'b1, 1'b0, rv_trap_pkg::width_word, addr & ~32'h3, pc);
    expect_quiet("aligned word load");
    issue_mem(1'b0, 1'b1, rv_trap_pkg::width_byte, addr, pc);
    expect_quiet("byte store at an odd address");
    issue_mem(1'b1, 1'b0, rv_trap_pkg::width_half_u, addr & ~32'h1, pc);
    expect_quiet("aligned unsigned half load");
  endtask

  task automatic mret_return();
    logic [31:0] target;
    logic [31:0] rdata;
    target = rand_word() & ~32'h3;
    csr_op(3'b001, rv_trap_pkg::csr_mepc, 5'd7, target, rdata);
    // MPIE set, MIE clear as after a trap
    csr_op(3'b001, rv_trap_pkg::csr_mstatus, 5'd7, 32'h80, rdata);
    @(posedge clk);
    id_mret <= 1'b1;
    @(posedge clk);
    id_mret <= 1'b0;
    expect_redirect(target, "mret");
    @(posedge clk);
    expect_quiet("after mret");
    expect_csr(rv_trap_pkg::csr_mstatus, 32'h88, "mstatus after mret");
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    errors     = 0;
    checks     = 0;
    lfsr_state = 16'd57014;
    rst_n              <= 1'b0;
    if_pc              <= '0;
    if_valid           <= 1'b0;
    id_illegal_inst    <= 1'b0;
    id_ecall           <= 1'b0;
    id_ebreak          <= 1'b0;
    id_mret            <= 1'b0;
    id_pc              <= '0;
    id_instruction.raw <= 32'h0;
    id_valid           <= 1'b0;
    mem_addr           <= '0;
    mem_read           <= 1'b0;
    mem_write          <= 1'b0;
    mem_funct3         <= 3'b000;
    mem_pc             <= '0;
    mem_valid          <= 1'b0;
    csr_valid          <= 1'b0;
    csr_inst.raw       <= 32'h0;
    csr_wdata          <= '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    check_reset_state();
    run_csr_access();
    trap_from_id(0);
    trap_from_id(1);
    trap_from_id(2);
    priority_and_fetch();
    flushed_exception();
    misaligned_access();
    mret_return();

    @(posedge clk);
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* design/exception_unit.sv */
// ====================
// Exception detection
// Checks IF, ID and MEM stage status and picks the
// highest-priority synchronous exception
// ====================

`timescale 1ns/100ps

`include "rv_macros.svh"

module exception_unit (
  // IF stage
  input  logic [`XLEN-1:0]      if_pc,
  input  logic                  if_valid,
  // ID stage
  input  logic                  id_illegal_inst,
  input  logic                  id_ecall,
  input  logic                  id_ebreak,
  input  logic [`XLEN-1:0]      id_pc,
  input  rv_trap_pkg::inst_u    id_instruction,
  input  logic                  id_valid,
  // MEM stage
  input  logic [`XLEN-1:0]      mem_addr,
  input  logic                  mem_read,
  input  logic                  mem_write,
  input  logic [2:0]            mem_funct3,
  input  logic [`XLEN-1:0]      mem_pc,
  input  logic                  mem_valid,
  // mmisalign bit 0
  input  logic                  misalign_trap_en,
  // Selected exception
  output logic                  exception,
  output rv_trap_pkg::cause_e   exception_code,
  output logic [`XLEN-1:0]      exception_pc,
  output logic [`XLEN-1:0]      exception_val
);

  localparam bit c_ext = `ENABLE_C_EXT;

  logic if_misaligned;
  logic id_ebreak_exc;
  logic id_ecall_exc;
  logic id_illegal_exc;
  logic mem_half;
  logic mem_word;
  logic addr_misaligned;
  logic load_misaligned;
  logic store_misaligned;

  // ====================
  // Per-stage detection
  // ====================

  // Fetch alignment, 2 bytes with C, 4 bytes without
  assign if_misaligned = if_valid && (c_ext ? if_pc[0] : (if_pc[1:0] != 2'b00));

  assign id_ebreak_exc  = id_valid && id_ebreak;
  assign id_ecall_exc   = id_valid && id_ecall;
  assign id_illegal_exc = id_valid && id_illegal_inst;

  // Access size from funct3, byte accesses never fault
  always_comb begin
    mem_half = 1'b0;
    mem_word = 1'b0;
    case (mem_funct3)
      rv_trap_pkg::width_half,
      rv_trap_pkg::width_half_u: mem_half = 1'b1;
      rv_trap_pkg::width_word,
      rv_trap_pkg::width_word_u: mem_word = 1'b1;
      default: ;
    endcase
  end

  assign addr_misaligned = (mem_half && mem_addr[0]) ||
                           (mem_word && (mem_addr[1:0] != 2'b00));

  // Misalignment traps only when enabled at run time
  assign load_misaligned  = mem_valid && mem_read && misalign_trap_en && addr_misaligned;
  assign store_misaligned = mem_valid && mem_write && misalign_trap_en && addr_misaligned;

  // ====================
  // Priority select
  // ====================

  always_comb begin
    exception      = 1'b0;
    exception_code = rv_trap_pkg::inst_misaligned;
    exception_pc   = '0;
    exception_val  = '0;
    if (if_misaligned) begin
      exception      = 1'b1;
      exception_code = rv_trap_pkg::inst_misaligned;
      exception_pc   = if_pc;
      exception_val  = if_pc;
    end else if (id_ebreak_exc) begin
      exception      = 1'b1;
      exception_code = rv_trap_pkg::breakpoint;
      exception_pc   = id_pc;
      exception_val  = id_pc;
    end else if (id_ecall_exc) begin
      // mtval stays zero for ecall
      exception      = 1'b1;
      exception_code = rv_trap_pkg::ecall_m;
      exception_pc   = id_pc;
    end else if (id_illegal_exc) begin
      // Faulting instruction bits go to mtval
      exception          = 1'b1;
      exception_code     = rv_trap_pkg::illegal_inst;
      exception_pc       = id_pc;
      exception_val[31:0] = id_instruction.raw;
    end else if (load_misaligned) begin
      exception      = 1'b1;
      exception_code = rv_trap_pkg::load_misaligned;
      exception_pc   = mem_pc;
      exception_val  = mem_addr;
    end else if (store_misaligned) begin
      exception      = 1'b1;
      exception_code = rv_trap_pkg::store_misaligned;
      exception_pc   = mem_pc;
      exception_val  = mem_addr;
    end
  end

endmodule

/* design/rv_macros.svh */
// ====================
// RV32 core build values
// Register width and compressed-ISA switch
// ====================

`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Register and address width
`define XLEN 32

// Compressed instruction support
// 1 means 2-byte fetch alignment, 0 means 4-byte
`define ENABLE_C_EXT 0

`endif

/* design/rv_trap_pkg.sv */
// ====================
// Machine-mode trap types
// Cause codes, memory widths, CSR addresses, instruction word
// ====================

package rv_trap_pkg;

  // Exception cause codes, synchronous only
  typedef enum logic [4:0] {
    inst_misaligned  = 5'd0,
    illegal_inst     = 5'd2,
    breakpoint       = 5'd3,
    load_misaligned  = 5'd4,
    store_misaligned = 5'd6,
    ecall_m          = 5'd11
  } cause_e;

  // Load/store funct3 encodings
  typedef enum logic [2:0] {
    width_byte   = 3'b000,
    width_half   = 3'b001,
    width_word   = 3'b010,
    width_byte_u = 3'b100,
    width_half_u = 3'b101,
    width_word_u = 3'b110
  } mem_width_e;

  // Trap CSR map, mmisalign is custom
  typedef enum logic [11:0] {
    csr_mstatus   = 12'h300,
    csr_mtvec     = 12'h305,
    csr_mepc      = 12'h341,
    csr_mcause    = 12'h342,
    csr_mtval     = 12'h343,
    csr_mmisalign = 12'h7c0
  } csr_addr_e;

  // I-type layout, csr field sits in the immediate
  typedef struct packed {
    logic [11:0] csr;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // Instruction word seen raw or as fields
  typedef union packed {
    logic [31:0] raw;
    i_type_t     i;
  } inst_u;

endpackage

/* design/trap_controller.sv */
// ====================
// Trap controller
// Qualifies exceptions and mret, registers a one-cycle
// redirect and flush
// ====================

`timescale 1ns/100ps

`include "rv_macros.svh"

module trap_controller (
  input  logic                  clk,
  input  logic                  rst_n,
  // From exception detection
  input  logic                  exception,
  input  rv_trap_pkg::cause_e   exception_code,
  input  logic [`XLEN-1:0]      exception_pc,
  input  logic [`XLEN-1:0]      exception_val,
  input  logic                  id_mret,
  // Targets from the CSR file
  input  logic [`XLEN-1:0]      mtvec_base,
  input  logic [`XLEN-1:0]      mepc_value,
  // Updates to the CSR file
  output logic                  trap_take,
  output rv_trap_pkg::cause_e   trap_code,
  output logic [`XLEN-1:0]      trap_pc,
  output logic [`XLEN-1:0]      trap_val,
  output logic                  mret_take,
  // To the pipeline
  output logic                  redirect_valid,
  output logic [`XLEN-1:0]      redirect_pc,
  output logic                  flush
);

  logic             redirect_q;
  logic [`XLEN-1:0] target_q;

  // Instructions in the redirect cycle are being flushed
  assign trap_take = exception && !redirect_q;

  // Exception wins over mret
  assign mret_take = id_mret && !exception && !redirect_q;

  assign trap_code = exception_code;
  assign trap_pc   = exception_pc;
  assign trap_val  = exception_val;

  // Redirect valid for exactly one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      redirect_q <= 1'b0;
    end else begin
      redirect_q <= trap_take || mret_take;
    end
  end

  // Target, mtvec on trap, mepc on mret
  always_ff @(posedge clk) begin
    if (trap_take) begin
      target_q <= mtvec_base;
    end else if (mret_take) begin
      target_q <= mepc_value;
    end
  end

  assign redirect_valid = redirect_q;
  assign redirect_pc    = target_q;
  assign flush          = redirect_q;

endmodule

/* design/trap_csr_file.sv */
// ====================
// Trap CSR file
// mtvec, mepc, mcause, mtval, mstatus MIE/MPIE and mmisalign,
// with csrrw/csrrs/csrrc decode
// ====================

`timescale 1ns/100ps

`include "rv_macros.svh"

module trap_csr_file (
  input  logic                  clk,
  input  logic                  rst_n,
  // CSR instruction port
  input  logic                  csr_valid,
  input  rv_trap_pkg::inst_u    csr_inst,
  input  logic [`XLEN-1:0]      csr_wdata,
  output logic [`XLEN-1:0]      csr_rdata,
  // Trap and mret updates
  input  logic                  trap_take,
  input  rv_trap_pkg::cause_e   trap_code,
  input  logic [`XLEN-1:0]      trap_pc,
  input  logic [`XLEN-1:0]      trap_val,
  input  logic                  mret_take,
  // State to the rest of the trap path
  output logic [`XLEN-1:0]      mtvec_base,
  output logic [`XLEN-1:0]      mepc_value,
  output logic                  misalign_trap_en
);

  // SYSTEM opcode and CSR funct3 values
  localparam logic [6:0] op_system = 7'b1110011;
  localparam logic [2:0] f3_csrrw  = 3'b001;
  localparam logic [2:0] f3_csrrs  = 3'b010;
  localparam logic [2:0] f3_csrrc  = 3'b011;

  logic [`XLEN-1:0]    mtvec_q;
  logic [`XLEN-1:0]    mepc_q;
  rv_trap_pkg::cause_e mcause_q;
  logic [`XLEN-1:0]    mtval_q;
  logic                mie_q;
  logic                mpie_q;
  logic                misalign_q;

  logic                csr_op;
  logic                csr_we;
  logic [`XLEN-1:0]    csr_old;
  logic [`XLEN-1:0]    csr_new;

  // ====================
  // Decode and read
  // ====================

  assign csr_op = csr_valid && (csr_inst.i.opcode == op_system) &&
                  ((csr_inst.i.funct3 == f3_csrrw) ||
                   (csr_inst.i.funct3 == f3_csrrs) ||
                   (csr_inst.i.funct3 == f3_csrrc));

  // Set/clear with rs1 = x0 is a pure read
  assign csr_we = csr_op && ((csr_inst.i.funct3 == f3_csrrw) || (csr_inst.i.rs1 != 5'd0));

  // Old value, unknown addresses read 0
  always_comb begin
    csr_old = '0;
    case (csr_inst.i.csr)
      rv_trap_pkg::csr_mstatus: begin
        csr_old[3] = mie_q;
        csr_old[7] = mpie_q;
      end
      rv_trap_pkg::csr_mtvec:     csr_old = mtvec_q;
      rv_trap_pkg::csr_mepc:      csr_old = mepc_q;
      rv_trap_pkg::csr_mcause:    csr_old[4:0] = mcause_q;
      rv_trap_pkg::csr_mtval:     csr_old = mtval_q;
      rv_trap_pkg::csr_mmisalign: csr_old[0] = misalign_q;
      default: ;
    endcase
  end

  assign csr_rdata = csr_old;

  // Write value by operation
  always_comb begin
    case (csr_inst.i.funct3)
      f3_csrrs: csr_new = csr_old | csr_wdata;
      f3_csrrc: csr_new = csr_old & ~csr_wdata;
      default:  csr_new = csr_wdata;
    endcase
  end

  // ====================
  // Registers
  // ====================

  // Trap update beats a CSR write to the same register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mtvec_q    <= '0;
      mepc_q     <= '0;
      mcause_q   <= rv_trap_pkg::inst_misaligned;
      mtval_q    <= '0;
      mie_q      <= 1'b0;
      mpie_q     <= 1'b0;
      misalign_q <= 1'b0;
    end else begin
      if (trap_take) begin
        // Low two pc bits forced to 0
        mepc_q   <= {trap_pc[`XLEN-1:2], 2'b00};
        mcause_q <= trap_code;
        mtval_q  <= trap_val;
        mpie_q   <= mie_q;
        mie_q    <= 1'b0;
      end else begin
        if (csr_we && (csr_inst.i.csr == rv_trap_pkg::csr_mepc))
          mepc_q <= {csr_new[`XLEN-1:2], 2'b00};
        if (csr_we && (csr_inst.i.csr == rv_trap_pkg::csr_mcause))
          mcause_q <= rv_trap_pkg::cause_e'(csr_new[4:0]);
        if (csr_we && (csr_inst.i.csr == rv_trap_pkg::csr_mtval))
          mtval_q <= csr_new;
        // mret restores interrupt enable
        if (mret_take) begin
          mie_q <= mpie_q;
        end else if (csr_we && (csr_inst.i.csr == rv_trap_pkg::csr_mstatus)) begin
          mie_q  <= csr_new[3];
          mpie_q <= csr_new[7];
        end
      end
      // Not touched by traps
      if (csr_we && (csr_inst.i.csr == rv_trap_pkg::csr_mtvec))
        mtvec_q <= {csr_new[`XLEN-1:2], 2'b00};
      if (csr_we && (csr_inst.i.csr == rv_trap_pkg::csr_mmisalign))
        misalign_q <= csr_new[0];
    end
  end

  assign mtvec_base       = mtvec_q;
  assign mepc_value       = mepc_q;
  assign misalign_trap_en = misalign_q;

endmodule

/* design/trap_top.sv */
// ====================
// Trap path top
// Exception detection, trap controller and CSR file
// ====================

`timescale 1ns/100ps

`include "rv_macros.svh"

module trap_top (
  input  logic                  clk,
  input  logic                  rst_n,
  // IF stage
  input  logic [`XLEN-1:0]      if_pc,
  input  logic                  if_valid,
  // ID stage
  input  logic                  id_illegal_inst,
  input  logic                  id_ecall,
  input  logic                  id_ebreak,
  input  logic                  id_mret,
  input  logic [`XLEN-1:0]      id_pc,
  input  rv_trap_pkg::inst_u    id_instruction,
  input  logic                  id_valid,
  // MEM stage
  input  logic [`XLEN-1:0]      mem_addr,
  input  logic                  mem_read,
  input  logic                  mem_write,
  input  logic [2:0]            mem_funct3,
  input  logic [`XLEN-1:0]      mem_pc,
  input  logic                  mem_valid,
  // CSR access
  input  logic                  csr_valid,
  input  rv_trap_pkg::inst_u    csr_inst,
  input  logic [`XLEN-1:0]      csr_wdata,
  output logic [`XLEN-1:0]      csr_rdata,
  // Redirect to fetch
  output logic                  redirect_valid,
  output logic [`XLEN-1:0]      redirect_pc,
  output logic                  flush
);

  // Detection to controller
  logic                exception;
  rv_trap_pkg::cause_e exception_code;
  logic [`XLEN-1:0]    exception_pc;
  logic [`XLEN-1:0]    exception_val;

  // Controller to CSR file
  logic                trap_take;
  rv_trap_pkg::cause_e trap_code;
  logic [`XLEN-1:0]    trap_pc;
  logic [`XLEN-1:0]    trap_val;
  logic                mret_take;

  // CSR file back to the others
  logic [`XLEN-1:0]    mtvec_base;
  logic [`XLEN-1:0]    mepc_value;
  logic                misalign_trap_en;

  exception_unit u_exception_unit (
    .if_pc            (if_pc),
    .if_valid         (if_valid),
    .id_illegal_inst  (id_illegal_inst),
    .id_ecall         (id_ecall),
    .id_ebreak        (id_ebreak),
    .id_pc            (id_pc),
    .id_instruction   (id_instruction),
    .id_valid         (id_valid),
    .mem_addr         (mem_addr),
    .mem_read         (mem_read),
    .mem_write        (mem_write),
    .mem_funct3       (mem_funct3),
    .mem_pc           (mem_pc),
    .mem_valid        (mem_valid),
    .misalign_trap_en (misalign_trap_en),
    .exception        (exception),
    .exception_code   (exception_code),
    .exception_pc     (exception_pc),
    .exception_val    (exception_val)
  );

  trap_controller u_trap_controller (
    .clk            (clk),
    .rst_n          (rst_n),
    .exception      (exception),
    .exception_code (exception_code),
    .exception_pc   (exception_pc),
    .exception_val  (exception_val),
    .id_mret        (id_mret),
    .mtvec_base     (mtvec_base),
    .mepc_value     (mepc_value),
    .trap_take      (trap_take),
    .trap_code      (trap_code),
    .trap_pc        (trap_pc),
    .trap_val       (trap_val),
    .mret_take      (mret_take),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .flush          (flush)
  );

  trap_csr_file u_trap_csr_file (
    .clk              (clk),
    .rst_n            (rst_n),
    .csr_valid        (csr_valid),
    .csr_inst         (csr_inst),
    .csr_wdata        (csr_wdata),
    .csr_rdata        (csr_rdata),
    .trap_take        (trap_take),
    .trap_code        (trap_code),
    .trap_pc          (trap_pc),
    .trap_val         (trap_val),
    .mret_take        (mret_take),
    .mtvec_base       (mtvec_base),
    .mepc_value       (mepc_value),
    .misalign_trap_en (misalign_trap_en)
  );

endmodule

/* sources.f */
+incdir+design
design/rv_trap_pkg.sv
design/exception_unit.sv
design/trap_csr_file.sv
design/trap_controller.sv
design/trap_top.sv
bench/trap_tb.sv
